// ==== source/lsu_pkg.sv ====
package lsu_pkg;

  localparam int XLEN_W          = 64;
  localparam int VADDR_W         = 32;
  localparam int PADDR_W         = 16;
  localparam int PAGE_W          = 12;
  localparam int DCACHE_DATA_B_W = 16;
  localparam int DCACHE_LINES    = 64;

  localparam int DCACHE_OFF_W = $clog2(DCACHE_DATA_B_W);  // Byte offset in a line
  localparam int DCACHE_IDX_W = $clog2(DCACHE_LINES);
  localparam int VPN_W        = VADDR_W - PAGE_W;
  localparam int PPN_W        = PADDR_W - PAGE_W;
  localparam int TLB_IDX_W    = 2;  // Sized for 4 entries

  typedef logic [XLEN_W-1:0]            xdata_t;
  typedef logic [VADDR_W-1:0]           vaddr_t;
  typedef logic [PADDR_W-1:0]           paddr_t;
  typedef logic [4:0]                   reg_idx_t;
  typedef logic [31:0]                  inst_t;
  typedef logic [DCACHE_DATA_B_W*8-1:0] line_t;

  typedef enum logic [1:0] {SIZE_B, SIZE_H, SIZE_W, SIZE_DW} size_t;
  typedef enum logic {SIGN_U, SIGN_S} sign_t;
  typedef enum logic [1:0] {CAT_LD, CAT_ST, CAT_OTHER} inst_cat_t;

  typedef struct packed {
    logic      valid;
    inst_t     inst;
    inst_cat_t cat;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
  } issue_t;

  typedef struct packed {
    logic                 valid;
    logic [TLB_IDX_W-1:0] entry;
    logic [VPN_W-1:0]     vpn;
    logic [PPN_W-1:0]     ppn;
  } tlb_fill_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    xdata_t   data;
  } wb_t;

  typedef struct packed {
    logic   update;
    logic   tlb_miss;
    vaddr_t vaddr;
    paddr_t paddr;
  } ex1_update_t;

endpackage

// ==== source/lsu_ctrl_decoder.sv ====
`timescale 1ns/1ps

module lsu_ctrl_decoder (
  input  lsu_pkg::inst_t i_inst,
  output lsu_pkg::size_t o_size,
  output lsu_pkg::sign_t o_sign,
  output logic           o_is_load,
  output logic           o_is_store
);
  import lsu_pkg::*;

  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];

  always_comb begin
    o_size     = size_t'(w_funct3[1:0]);  // funct3 low bits match size encoding
    o_sign     = SIGN_U;
    o_is_load  = 1'b0;
    o_is_store = 1'b0;
    case (w_opcode)
      OPC_LOAD: begin
        o_is_load = (w_funct3 != 3'b111);  // No LDU in RV64
        o_sign    = w_funct3[2] ? SIGN_U : SIGN_S;
      end
      OPC_STORE: o_is_store = !w_funct3[2];
      default:   o_size = SIZE_B;
    endcase
  end

endmodule

// ==== source/lsu_tlb.sv ====
`timescale 1ns/1ps

module lsu_tlb #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  lsu_pkg::tlb_fill_t i_fill,
  input  lsu_pkg::vaddr_t    i_vaddr,
  output logic               o_miss,
  output lsu_pkg::paddr_t    o_paddr
);
  import lsu_pkg::*;

  logic             r_valid [TLB_ENTRIES];
  logic [VPN_W-1:0] r_vpn   [TLB_ENTRIES];
  logic [PPN_W-1:0] r_ppn   [TLB_ENTRIES];

  logic [VPN_W-1:0] w_vpn;
  logic             w_hit;
  logic [PPN_W-1:0] w_ppn;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        r_valid[i] <= 1'b0;
        r_vpn[i]   <= '0;
        r_ppn[i]   <= '0;
      end
    end else if (i_fill.valid) begin
      r_valid[i_fill.entry] <= 1'b1;
      r_vpn[i_fill.entry]   <= i_fill.vpn;
      r_ppn[i_fill.entry]   <= i_fill.ppn;
    end
  end

  assign w_vpn = i_vaddr[VADDR_W-1:PAGE_W];

  // Fully associative match
  always_comb begin
    w_hit = 1'b0;
    w_ppn = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (r_valid[i] && (r_vpn[i] == w_vpn)) begin
        w_hit = 1'b1;
        w_ppn = r_ppn[i];
      end
    end
  end

  assign o_miss  = !w_hit;
  assign o_paddr = w_hit ? {w_ppn, i_vaddr[PAGE_W-1:0]} : '0;

endmodule

// ==== source/lsu_dcache_data.sv ====
`timescale 1ns/1ps

module lsu_dcache_data (
  input  logic            i_clk,
  input  logic            i_rd_valid,
  input  lsu_pkg::paddr_t i_rd_paddr,
  output lsu_pkg::line_t  o_rd_line,
  input  logic            i_wr_valid,
  input  lsu_pkg::paddr_t i_wr_paddr,
  input  lsu_pkg::size_t  i_wr_size,
  input  lsu_pkg::xdata_t i_wr_data
);
  import lsu_pkg::*;

  line_t r_mem [DCACHE_LINES];

  logic [DCACHE_IDX_W-1:0]    w_rd_idx;
  logic [DCACHE_IDX_W-1:0]    w_wr_idx;
  logic [DCACHE_OFF_W-1:0]    w_wr_off;
  logic [DCACHE_DATA_B_W-1:0] w_wr_be;
  line_t                      w_wr_line;

  initial begin
    for (int i = 0; i < DCACHE_LINES; i++) begin
      r_mem[i] = '0;
    end
  end

  assign w_rd_idx = i_rd_paddr[DCACHE_OFF_W +: DCACHE_IDX_W];
  assign w_wr_idx = i_wr_paddr[DCACHE_OFF_W +: DCACHE_IDX_W];

  // Offset rounded down to the access size, same slice the load side picks
  always_comb begin
    case (i_wr_size)
      SIZE_H:  w_wr_off = {i_wr_paddr[DCACHE_OFF_W-1:1], 1'b0};
      SIZE_W:  w_wr_off = {i_wr_paddr[DCACHE_OFF_W-1:2], 2'b00};
      SIZE_DW: w_wr_off = {i_wr_paddr[DCACHE_OFF_W-1:3], 3'b000};
      default: w_wr_off = i_wr_paddr[DCACHE_OFF_W-1:0];
    endcase
    case (i_wr_size)
      SIZE_H:  w_wr_be = 'h3;
      SIZE_W:  w_wr_be = 'hf;
      SIZE_DW: w_wr_be = 'hff;
      default: w_wr_be = 'h1;
    endcase
    w_wr_be   = w_wr_be << w_wr_off;
    w_wr_line = line_t'(i_wr_data) << {w_wr_off, 3'b000};
  end

  always_ff @(posedge i_clk) begin
    if (i_rd_valid) o_rd_line <= r_mem[w_rd_idx];
    if (i_wr_valid) begin
      for (int b = 0; b < DCACHE_DATA_B_W; b++) begin
        if (w_wr_be[b]) r_mem[w_wr_idx][b*8 +: 8] <= w_wr_line[b*8 +: 8];
      end
    end
  end

endmodule

// ==== source/lsu_regfile.sv ====
`timescale 1ns/1ps

module lsu_regfile (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  lsu_pkg::reg_idx_t i_rs1,
  input  lsu_pkg::reg_idx_t i_rs2,
  output lsu_pkg::xdata_t   o_rs1_data,
  output lsu_pkg::xdata_t   o_rs2_data,
  input  lsu_pkg::wb_t      i_wr0,
  input  lsu_pkg::wb_t      i_wr1
);
  import lsu_pkg::*;

  xdata_t r_regs [1:31];  // x0 has no storage

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 1; i < 32; i++) begin
        r_regs[i] <= '0;
      end
    end else begin
      if (i_wr1.valid && (i_wr1.rd != '0)) begin
        r_regs[i_wr1.rd] <= i_wr1.data;
      end
      // Port 0 last so it wins on the same rd
      if (i_wr0.valid && (i_wr0.rd != '0)) begin
        r_regs[i_wr0.rd] <= i_wr0.data;
      end
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : r_regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : r_regs[i_rs2];

endmodule

// ==== source/lsu_pipe.sv ====
`timescale 1ns/1ps

module lsu_pipe #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  lsu_pkg::issue_t      i_issue,
  output lsu_pkg::reg_idx_t    o_rs1,
  output lsu_pkg::reg_idx_t    o_rs2,
  input  lsu_pkg::xdata_t      i_rs1_data,
  input  lsu_pkg::xdata_t      i_rs2_data,
  input  lsu_pkg::tlb_fill_t   i_tlb_fill,
  output lsu_pkg::ex1_update_t o_ex1_update,
  output logic                 o_rd_valid,
  output lsu_pkg::paddr_t      o_rd_paddr,
  input  lsu_pkg::line_t       i_rd_line,
  output logic                 o_wr_valid,
  output lsu_pkg::paddr_t      o_wr_paddr,
  output lsu_pkg::size_t       o_wr_size,
  output lsu_pkg::xdata_t      o_wr_data,
  output lsu_pkg::wb_t         o_ex3_wb
);
  import lsu_pkg::*;

  typedef struct packed {
    size_t size;
    sign_t sign;
    logic  is_load;
    logic  is_store;
  } pipe_ctrl_t;

  issue_t     r_ex0_issue;
  pipe_ctrl_t w_ex0_ctrl;

  issue_t     r_ex1_issue;
  pipe_ctrl_t r_ex1_ctrl;
  vaddr_t     w_ex1_imm;
  vaddr_t     w_ex1_vaddr;
  logic       w_ex1_miss;
  paddr_t     w_ex1_paddr;
  logic       w_ex1_go;

  issue_t     r_ex2_issue;
  issue_t     w_ex2_issue_next;
  pipe_ctrl_t r_ex2_ctrl;
  paddr_t     r_ex2_paddr;
  xdata_t     w_ex2_raw;
  xdata_t     w_ex2_data;

  issue_t     r_ex3_issue;
  issue_t     w_ex3_issue_next;
  xdata_t     r_ex3_data;

  always_comb begin
    w_ex2_issue_next       = r_ex1_issue;
    w_ex2_issue_next.valid = w_ex1_go;  // Miss drops it here
    w_ex3_issue_next       = r_ex2_issue;
    w_ex3_issue_next.valid = r_ex2_issue.valid & r_ex2_ctrl.is_load & (r_ex2_issue.rd != '0);
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_issue <= '0;
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
      r_ex2_issue <= '0;
      r_ex2_ctrl  <= '0;
      r_ex3_issue <= '0;
    end else begin
      r_ex0_issue <= i_issue;
      r_ex1_issue <= r_ex0_issue;
      r_ex1_ctrl  <= w_ex0_ctrl;
      r_ex2_issue <= w_ex2_issue_next;
      r_ex2_ctrl  <= r_ex1_ctrl;
      r_ex3_issue <= w_ex3_issue_next;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_paddr <= w_ex1_paddr;
    r_ex3_data  <= w_ex2_data;
  end

  lsu_ctrl_decoder u_decoder (
    .i_inst     (r_ex0_issue.inst),
    .o_size     (w_ex0_ctrl.size),
    .o_sign     (w_ex0_ctrl.sign),
    .o_is_load  (w_ex0_ctrl.is_load),
    .o_is_store (w_ex0_ctrl.is_store)
  );

  // EX1 address and translation
  assign o_rs1 = r_ex1_issue.rs1;
  assign o_rs2 = r_ex1_issue.rs2;

  always_comb begin
    if (r_ex1_ctrl.is_store) begin
      w_ex1_imm = {{(VADDR_W-12){r_ex1_issue.inst[31]}}, r_ex1_issue.inst[31:25],
                   r_ex1_issue.inst[11:7]};
    end else begin
      w_ex1_imm = {{(VADDR_W-12){r_ex1_issue.inst[31]}}, r_ex1_issue.inst[31:20]};
    end
  end

  assign w_ex1_vaddr = i_rs1_data[VADDR_W-1:0] + w_ex1_imm;

  lsu_tlb #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) u_tlb (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_fill    (i_tlb_fill),
    .i_vaddr   (w_ex1_vaddr),
    .o_miss    (w_ex1_miss),
    .o_paddr   (w_ex1_paddr)
  );

  assign w_ex1_go = r_ex1_issue.valid & !w_ex1_miss;

  assign o_ex1_update.update   = r_ex1_issue.valid;
  assign o_ex1_update.tlb_miss = r_ex1_issue.valid & w_ex1_miss;
  assign o_ex1_update.vaddr    = w_ex1_vaddr;
  assign o_ex1_update.paddr    = w_ex1_paddr;

  assign o_rd_valid = w_ex1_go & r_ex1_ctrl.is_load;
  assign o_rd_paddr = w_ex1_paddr;
  assign o_wr_valid = w_ex1_go & r_ex1_ctrl.is_store;  // RAM takes it at the next edge
  assign o_wr_paddr = w_ex1_paddr;
  assign o_wr_size  = r_ex1_ctrl.size;
  assign o_wr_data  = i_rs2_data;

  // EX2 aligned slice, low address bits below the size ignored
  always_comb begin
    case (r_ex2_ctrl.size)
      SIZE_DW: w_ex2_raw = i_rd_line[{r_ex2_paddr[DCACHE_OFF_W-1:3], 6'b0} +: 64];
      SIZE_W:  w_ex2_raw = xdata_t'(i_rd_line[{r_ex2_paddr[DCACHE_OFF_W-1:2], 5'b0} +: 32]);
      SIZE_H:  w_ex2_raw = xdata_t'(i_rd_line[{r_ex2_paddr[DCACHE_OFF_W-1:1], 4'b0} +: 16]);
      default: w_ex2_raw = xdata_t'(i_rd_line[{r_ex2_paddr[DCACHE_OFF_W-1:0], 3'b0} +: 8]);
    endcase
    w_ex2_data = w_ex2_raw;
    if (r_ex2_ctrl.sign == SIGN_S) begin
      case (r_ex2_ctrl.size)
        SIZE_W:  w_ex2_data = {{(XLEN_W-32){w_ex2_raw[31]}}, w_ex2_raw[31:0]};
        SIZE_H:  w_ex2_data = {{(XLEN_W-16){w_ex2_raw[15]}}, w_ex2_raw[15:0]};
        SIZE_B:  w_ex2_data = {{(XLEN_W-8){w_ex2_raw[7]}}, w_ex2_raw[7:0]};
        default: w_ex2_data = w_ex2_raw;
      endcase
    end
  end

  assign o_ex3_wb.valid = r_ex3_issue.valid;
  assign o_ex3_wb.rd    = r_ex3_issue.rd;
  assign o_ex3_wb.data  = r_ex3_data;

endmodule

// ==== source/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  lsu_pkg::issue_t      i_issue,
  input  lsu_pkg::wb_t         i_alu_wr,
  input  lsu_pkg::tlb_fill_t   i_tlb_fill,
  output lsu_pkg::ex1_update_t o_ex1_update,
  output lsu_pkg::wb_t         o_ex3_wb
);
  import lsu_pkg::*;

  reg_idx_t w_rs1;
  reg_idx_t w_rs2;
  xdata_t   w_rs1_data;
  xdata_t   w_rs2_data;
  logic     w_rd_valid;
  paddr_t   w_rd_paddr;
  line_t    w_rd_line;
  logic     w_wr_valid;
  paddr_t   w_wr_paddr;
  size_t    w_wr_size;
  xdata_t   w_wr_data;

  lsu_pipe #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) u_pipe (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_issue      (i_issue),
    .o_rs1        (w_rs1),
    .o_rs2        (w_rs2),
    .i_rs1_data   (w_rs1_data),
    .i_rs2_data   (w_rs2_data),
    .i_tlb_fill   (i_tlb_fill),
    .o_ex1_update (o_ex1_update),
    .o_rd_valid   (w_rd_valid),
    .o_rd_paddr   (w_rd_paddr),
    .i_rd_line    (w_rd_line),
    .o_wr_valid   (w_wr_valid),
    .o_wr_paddr   (w_wr_paddr),
    .o_wr_size    (w_wr_size),
    .o_wr_data    (w_wr_data),
    .o_ex3_wb     (o_ex3_wb)
  );

  // Load write-back on port 0, ALU pipes on port 1
  lsu_regfile u_regfile (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rs1      (w_rs1),
    .i_rs2      (w_rs2),
    .o_rs1_data (w_rs1_data),
    .o_rs2_data (w_rs2_data),
    .i_wr0      (o_ex3_wb),
    .i_wr1      (i_alu_wr)
  );

  lsu_dcache_data u_dcache_data (
    .i_clk      (i_clk),
    .i_rd_valid (w_rd_valid),
    .i_rd_paddr (w_rd_paddr),
    .o_rd_line  (w_rd_line),
    .i_wr_valid (w_wr_valid),
    .i_wr_paddr (w_wr_paddr),
    .i_wr_size  (w_wr_size),
    .i_wr_data  (w_wr_data)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk;  // 100 ns period
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (8) @(posedge o_clk);
    #1 o_reset_n = 1'b1;
  end

endmodule

// ==== verif/lsu_top_assert.sv ====
`timescale 1ns/1ps

module lsu_top_assert (
  input logic                 i_clk,
  input logic                 i_reset_n,
  input lsu_pkg::ex1_update_t i_ex1_update,
  input logic                 i_rd_valid,
  input logic                 i_wr_valid,
  input lsu_pkg::wb_t         i_ex3_wb
);

  a_no_wb_after_reset: assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> !i_ex3_wb.valid)
    else $error("write-back valid in the first cycle after reset");

  a_rd_wr_exclusive: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_rd_valid && i_wr_valid))
    else $error("RAM read and write requested in the same cycle");

  // EX1 to EX3 is two clock edges
  a_miss_no_wb: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $past(i_ex1_update.tlb_miss, 2) |-> !i_ex3_wb.valid)
    else $error("TLB miss in EX1 was followed by a write-back");

endmodule

bind lsu_pipe lsu_top_assert u_assert (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .i_ex1_update (o_ex1_update),
  .i_rd_valid   (o_rd_valid),
  .i_wr_valid   (o_wr_valid),
  .i_ex3_wb     (o_ex3_wb)
);

// ==== verif/tb_lsu_top.sv ====
`timescale 1ns/1ps

module tb_lsu_top;
  import lsu_pkg::*;

  localparam int MEM_BYTES = DCACHE_LINES * DCACHE_DATA_B_W;
  localparam logic [VPN_W-1:0] VPN_UNMAPPED = 20'h7fff0;

  typedef struct packed {
    logic [31:0] at;
    ex1_update_t val;
  } exp_upd_t;

  typedef struct packed {
    logic [31:0] at;
    wb_t         val;
  } exp_wb_t;

  logic        clk;
  logic        reset_n;
  issue_t      issue;
  wb_t         alu_wr;
  tlb_fill_t   tlb_fill;
  ex1_update_t ex1_update;
  wb_t         ex3_wb;

  logic [31:0]      seed = 32'd94188;
  int unsigned      cyc = 0;
  xdata_t           reg_model [32];
  logic [7:0]       mem_model [MEM_BYTES];
  logic             tlb_valid [4];
  logic [VPN_W-1:0] tlb_vpn [4];
  logic [PPN_W-1:0] tlb_ppn [4];
  issue_t           pend;  // Issued last cycle, evaluated once its EX1 view is known
  int unsigned      pend_at;
  exp_upd_t         exp_upd [$];
  exp_wb_t          exp_wb [$];

  tb_clk_gen u_clk_gen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  lsu_top dut_i (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_issue      (issue),
    .i_alu_wr     (alu_wr),
    .i_tlb_fill   (tlb_fill),
    .o_ex1_update (ex1_update),
    .o_ex3_wb     (ex3_wb)
  );

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed ^ (seed >> 15);  // Fold high bits down
  endfunction

  function automatic xdata_t rand64();
    xdata_t v;
    v[63:32] = lcg_next();
    v[31:0]  = lcg_next();
    return v;
  endfunction

  function automatic issue_t load_op(input logic [2:0] f3, input reg_idx_t rd,
                                     input reg_idx_t rs1, input logic [11:0] imm);
    issue_t iss;
    iss       = '0;
    iss.valid = 1'b1;
    iss.inst  = {imm, rs1, f3, rd, 7'b0000011};
    iss.cat   = CAT_LD;
    iss.rd    = rd;
    iss.rs1   = rs1;
    return iss;
  endfunction

  function automatic issue_t store_op(input logic [2:0] f3, input reg_idx_t rs1,
                                      input reg_idx_t rs2, input logic [11:0] imm);
    issue_t iss;
    iss       = '0;
    iss.valid = 1'b1;
    iss.inst  = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    iss.cat   = CAT_ST;
    iss.rs1   = rs1;
    iss.rs2   = rs2;
    return iss;
  endfunction

  function automatic wb_t alu_write(input reg_idx_t rd, input xdata_t d);
    wb_t w;
    w.valid = 1'b1;
    w.rd    = rd;
    w.data  = d;
    return w;
  endfunction

  function automatic ex1_update_t ref_translate(input vaddr_t va);
    ex1_update_t u;
    u.update   = 1'b1;
    u.tlb_miss = 1'b1;
    u.vaddr    = va;
    u.paddr    = '0;
    for (int e = 0; e < 4; e++) begin
      if (tlb_valid[e] && (tlb_vpn[e] == va[VADDR_W-1:PAGE_W])) begin
        u.tlb_miss = 1'b0;
        u.paddr    = {tlb_ppn[e], va[PAGE_W-1:0]};
      end
    end
    return u;
  endfunction

  // Aligned slice of the byte memory, extended by funct3
  function automatic xdata_t ref_load(input paddr_t pa, input logic [2:0] f3);
    int unsigned nb;
    int unsigned base;
    xdata_t      v;
    nb   = 1 << f3[1:0];
    base = (pa % MEM_BYTES) & ~(nb - 1);
    v    = '0;
    for (int b = 0; b < nb; b++) begin
      v[b*8 +: 8] = mem_model[base + b];
    end
    if (!f3[2] && (nb < 8) && v[nb*8-1]) begin
      v = v | (~64'd0 << (nb * 8));
    end
    return v;
  endfunction

  task automatic ref_store(input paddr_t pa, input logic [1:0] sz, input xdata_t d);
    int unsigned nb;
    int unsigned base;
    nb   = 1 << sz;
    base = (pa % MEM_BYTES) & ~(nb - 1);
    for (int b = 0; b < nb; b++) begin
      mem_model[base + b] = d[b*8 +: 8];
    end
  endtask

  task automatic model_exec(input issue_t iss, input int unsigned at);
    ex1_update_t u;
    exp_upd_t    eu;
    exp_wb_t     ew;
    xdata_t      v;
    vaddr_t      imm;
    logic        is_store;
    if (iss.valid) begin
      is_store = (iss.inst[6:0] == 7'b0100011);
      if (is_store) imm = {{20{iss.inst[31]}}, iss.inst[31:25], iss.inst[11:7]};
      else imm = {{20{iss.inst[31]}}, iss.inst[31:20]};
      u = ref_translate(reg_model[iss.rs1][VADDR_W-1:0] + imm);
      eu.at  = at + 2;  // EX1 two edges after the issue edge
      eu.val = u;
      exp_upd.push_back(eu);
      if (!u.tlb_miss) begin
        if (is_store) begin
          ref_store(u.paddr, iss.inst[13:12], reg_model[iss.rs2]);
        end else begin
          v = ref_load(u.paddr, iss.inst[14:12]);
          if (iss.rd != '0) begin
            ew.at        = at + 4;
            ew.val.valid = 1'b1;
            ew.val.rd    = iss.rd;
            ew.val.data  = v;
            exp_wb.push_back(ew);
            reg_model[iss.rd] = v;
          end
        end
      end
    end
  endtask

  // One cycle of drive, inputs change 1 ns after the edge
  task automatic step(input issue_t iss, input wb_t alu);
    issue  = iss;
    alu_wr = alu;
    if (alu.valid && (alu.rd != '0)) reg_model[alu.rd] = alu.data;
    model_exec(pend, pend_at);
    pend    = iss;
    pend_at = cyc;
    @(posedge clk);
    #1;
  endtask

  task automatic set_reg(input reg_idx_t rd, input xdata_t d);
    step('0, alu_write(rd, d));
  endtask

  task automatic fill_tlb(input logic [1:0] e, input logic [VPN_W-1:0] vpn,
                          input logic [PPN_W-1:0] ppn);
    tlb_fill.valid = 1'b1;
    tlb_fill.entry = e;
    tlb_fill.vpn   = vpn;
    tlb_fill.ppn   = ppn;
    tlb_valid[e]   = 1'b1;
    tlb_vpn[e]     = vpn;
    tlb_ppn[e]     = ppn;
    step('0, '0);
    tlb_fill = '0;
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopped on first error");
  endtask

  task automatic check_ex1_update(input ex1_update_t act, input ex1_update_t exp);
    if ((act.update !== exp.update) || (exp.update && (act !== exp))) begin
      fail_now($sformatf(
        "Mismatch at %0t: o_ex1_update got upd/miss/va/pa %b %b %h %h, exp %b %b %h %h",
        $time, act.update, act.tlb_miss, act.vaddr, act.paddr,
        exp.update, exp.tlb_miss, exp.vaddr, exp.paddr));
    end
  endtask

  task automatic check_wb(input wb_t act, input wb_t exp);
    if ((act.valid !== exp.valid) || (exp.valid && (act !== exp))) begin
      fail_now($sformatf(
        "Mismatch at %0t: o_ex3_wb got valid=%b rd=%0d data=%h, exp valid=%b rd=%0d data=%h",
        $time, act.valid, act.rd, act.data, exp.valid, exp.rd, exp.data));
    end
  endtask

  // Outputs sampled mid-cycle
  always @(negedge clk) begin
    ex1_update_t eu;
    wb_t         ew;
    if (reset_n) begin
      eu = '0;
      ew = '0;
      if ((exp_upd.size() != 0) && (exp_upd[0].at == cyc)) begin
        eu = exp_upd[0].val;
        exp_upd.delete(0);
      end
      if ((exp_wb.size() != 0) && (exp_wb[0].at == cyc)) begin
        ew = exp_wb[0].val;
        exp_wb.delete(0);
      end
      check_ex1_update(ex1_update, eu);
      check_wb(ex3_wb, ew);
    end
  end

  initial begin
    int          n;
    logic [31:0] r;
    logic [11:0] off;
    logic [2:0]  f3;
    reg_idx_t    rd;
    issue_t      iss;
    wb_t         alu;
    issue    = '0;
    alu_wr   = '0;
    tlb_fill = '0;
    pend     = '0;
    pend_at  = 0;
    for (int i = 0; i < 32; i++) reg_model[i] = '0;
    for (int i = 0; i < MEM_BYTES; i++) mem_model[i] = '0;
    for (int e = 0; e < 4; e++) begin
      tlb_valid[e] = 1'b0;
      tlb_vpn[e]   = '0;
      tlb_ppn[e]   = '0;
    end

    for (n = 0; (n < 20) && (reset_n !== 1'b1); n++) @(posedge clk);
    if (reset_n !== 1'b1) fail_now("Reset was never released");
    #1;

    // Reset and translation fills
    for (int i = 0; i < 4; i++) step('0, '0);
    for (int e = 0; e < 4; e++) begin
      fill_tlb(2'(e), 20'h10000 + 20'(e * 37), 4'(e * 5 + 2));
    end
    for (int e = 0; e < 4; e++) begin
      set_reg(5'(e + 1), {32'h0, tlb_vpn[e], 12'h800});  // Page bases, mid page
    end
    set_reg(5'd5, {32'h0, VPN_UNMAPPED, 12'h800});
    for (int e = 0; e < 4; e++) begin
      step(load_op(3'd3, 5'(16 + e), 5'(e + 1), 12'(lcg_next())), '0);
    end

    // Store then load, each size
    for (int sz = 0; sz < 4; sz++) begin
      set_reg(5'(8 + sz), rand64());
      off = 12'(lcg_next());
      step(store_op(3'(sz), 5'd1, 5'(8 + sz), off), '0);
      step(load_op(3'(sz), 5'd17, 5'd1, off), '0);
      if (sz < 3) step(load_op(3'(4 + sz), 5'd18, 5'd1, off), '0);
    end

    // Load result read back through the register file
    set_reg(5'd12, rand64());
    step(store_op(3'd3, 5'd2, 5'd12, 12'h010), '0);
    step(load_op(3'd3, 5'd20, 5'd2, 12'h010), '0);
    step('0, '0);
    step('0, '0);
    step(store_op(3'd3, 5'd3, 5'd20, 12'h100), '0);
    step(load_op(3'd3, 5'd21, 5'd3, 12'h100), '0);

    // Mixed widths over one doubleword
    for (int i = 0; i < 4; i++) begin
      set_reg(5'd9, rand64());
      off = 12'(lcg_next()) & 12'hff8;
      step(store_op(3'd3, 5'd4, 5'd9, off), '0);
      for (int f = 0; f < 7; f++) begin
        if (f != 3) step(load_op(3'(f), 5'd19, 5'd4, off | 12'(lcg_next() & 7)), '0);
      end
    end

    // TLB miss leaves the line untouched, x1 plus 0 lands on line 0 like paddr 0
    off = 12'h000;
    set_reg(5'd11, rand64());
    step(store_op(3'd3, 5'd1, 5'd11, off), '0);
    set_reg(5'd10, rand64());
    step(store_op(3'd3, 5'd5, 5'd10, off), '0);
    step(load_op(3'd3, 5'd22, 5'd5, off), '0);
    step(load_op(3'd3, 5'd23, 5'd1, off), '0);

    // Random back-to-back stream
    for (int i = 0; i < 300; i++) begin
      r = lcg_next();
      if (r[15]) begin
        iss = store_op({1'b0, r[17:16]}, 5'(r[2:0] % 5 + 1), 5'(8 + r[20:18]), r[14:3]);
      end else begin
        f3 = (r[18:16] == 3'd7) ? 3'd3 : r[18:16];
        rd = r[23:19];
        if ((rd != '0) && (rd < 5'd16)) rd = rd + 5'd16;  // Loads only write x16 and up
        iss = load_op(f3, rd, 5'(r[2:0] % 5 + 1), r[14:3]);
      end
      alu = r[31] ? alu_write(5'(8 + r[30:28]), rand64()) : '0;
      step(iss, alu);
    end

    for (n = 0; (n < 10) && ((exp_upd.size() != 0) || (exp_wb.size() != 0)); n++) begin
      step('0, '0);
    end
    if ((exp_upd.size() != 0) || (exp_wb.size() != 0)) begin
      fail_now("Expected results still pending after the pipe drained");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// ==== src.f ====
source/lsu_pkg.sv
source/lsu_ctrl_decoder.sv
source/lsu_tlb.sv
source/lsu_dcache_data.sv
source/lsu_regfile.sv
source/lsu_pipe.sv
source/lsu_top.sv
verif/tb_clk_gen.sv
verif/lsu_top_assert.sv
verif/tb_lsu_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status is the result
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_lsu_top \
    -Mdir obj_dir -f src.f &&
  ./obj_dir/Vtb_lsu_top || { echo "simulation failed"; exit 1; }
